//--- hdl/spi_frame_pkg.sv
// spi framing constants for the host control link
// frame and bit counter types, receiver phase enum

package spi_frame_pkg;

  ////////////////////
  // frame geometry

  // one write frame is address byte then value byte
  localparam int FRAME_BITS = 16;
  localparam int BYTE_BITS  = 8;

  // shift register contents, msb first on the wire
  typedef logic [FRAME_BITS-1:0] frame_t;

  // counts sclk rising edges, sticks at the top
  typedef logic [4:0] bit_count_t;

  localparam bit_count_t BIT_CNT_MAX    = 5'd31;
  // count value seen on the edge that completes the address byte
  localparam bit_count_t ADDR_LAST_BIT  = bit_count_t'(BYTE_BITS - 1);
  // count value seen on the edge that completes the frame
  localparam bit_count_t FRAME_LAST_BIT = bit_count_t'(FRAME_BITS - 1);
  // count required at cs_n release for a clean write
  localparam bit_count_t FRAME_DONE_CNT = bit_count_t'(FRAME_BITS);

  ////////////////////
  // receiver phase

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_ADDR,
    PH_DATA,
    PH_EXTRA
  } frame_phase_t;

endpackage

//--- hdl/smu_regs_pkg.sv
// control register map of the smu fpga
// register addresses, value types, reset values, device count

package smu_regs_pkg;

  ////////////////////
  // types

  typedef logic [7:0] reg_addr_t;
  // low nibble of a write sets, high nibble clears
  typedef logic [3:0] ctrl_nibble_t;
  typedef logic [7:0] read_byte_t;
  // rail monitor comparator inputs
  typedef logic [1:0] mon_rails_t;

  ////////////////////
  // addresses

  localparam reg_addr_t ADDR_LED        = 8'd7;
  localparam reg_addr_t ADDR_MUX        = 8'd8;
  localparam reg_addr_t ADDR_DAC        = 8'd9;
  localparam reg_addr_t ADDR_RAILS      = 8'd10;
  // write only, value byte ignored
  localparam reg_addr_t ADDR_SOFT_RESET = 8'd11;
  localparam reg_addr_t ADDR_CLAMP1     = 8'd15;
  // read only
  localparam reg_addr_t ADDR_MON_RAILS  = 8'd19;
  localparam reg_addr_t ADDR_RAILS_OE   = 8'd24;

  ////////////////////
  // reset values

  // led, mux, dac and rails all come up cleared
  localparam ctrl_nibble_t RST_DEFAULT  = 4'b0000;
  // clamp switches are active low, so all off
  localparam ctrl_nibble_t RST_CLAMP1   = 4'b1111;
  // rails output enable is active low. hold it off until the host is ready
  localparam ctrl_nibble_t RST_RAILS_OE = 4'b0001;

  ////////////////////
  // downstream spi devices

  // adc03, dac, ice flash, adc02
  localparam int NUM_DEVICES = 4;

endpackage

//--- hdl/reg_bus_if.sv
// register access bus between spi receiver and register block
// write strobe with address and value, read strobe with address and data

`timescale 1ns/1ps

interface reg_bus_if
  import spi_frame_pkg::*;
  import smu_regs_pkg::*;
();

  // write, one cycle pulse at a clean frame end
  logic                 wr_stb;
  reg_addr_t            wr_addr;
  logic [BYTE_BITS-1:0] wr_val;

  // read, one cycle pulse once the address byte is in
  logic                 rd_stb;
  reg_addr_t            rd_addr;
  // combinational from rd_addr
  read_byte_t           rd_data;

  // receiver side
  modport rx (
    output wr_stb, wr_addr, wr_val,
    output rd_stb, rd_addr,
    input  rd_data
  );

  // register side, takes every write in the cycle it shows up
  modport regs (
    input  wr_stb, wr_addr, wr_val,
    input  rd_addr,
    output rd_data
  );

endinterface

//--- hdl/spi_frame_rx.sv
// host spi frame receiver, oversampled on clk
// input synchronizers, edge detect, phase fsm, frame shift register,
// read and write strobes, readback shift out

`timescale 1ns/1ps

module spi_frame_rx
  import spi_frame_pkg::*;
  import smu_regs_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic sdo,
  reg_bus_if.rx bus
);

  // two flop synchronizers, [1] is the usable copy
  logic [1:0]   sclk_sync;
  logic [1:0]   cs_sync;
  logic [1:0]   mosi_sync;
  logic         sclk_prev;
  logic         cs_prev;

  logic         sclk_rise;
  logic         sclk_fall;
  logic         cs_fall;
  logic         cs_rise;

  frame_t       frame;
  bit_count_t   bit_cnt;
  frame_phase_t phase;

  // readback byte on its way out
  read_byte_t   tx_shift;
  logic         tx_step;
  logic         sdo_q;

  ////////////////////
  // sync and edges

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sclk_sync <= '0;
      // cs_n idles high
      cs_sync   <= '1;
      mosi_sync <= '0;
      sclk_prev <= 1'b0;
      cs_prev   <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_prev <= sclk_sync[1];
      cs_prev   <= cs_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;
  assign cs_fall   = ~cs_sync[1] & cs_prev;
  assign cs_rise   = cs_sync[1] & ~cs_prev;

  ////////////////////
  // phase fsm

  always_ff @(posedge clk)
  begin
    if (reset)
      phase <= PH_IDLE;
    else if (cs_rise)
      phase <= PH_IDLE;
    else
    begin
      case (phase)
        PH_IDLE:
          if (cs_fall)
            phase <= PH_ADDR;
        PH_ADDR:
          if (sclk_rise && bit_cnt == ADDR_LAST_BIT)
            phase <= PH_DATA;
        PH_DATA:
          if (sclk_rise && bit_cnt == FRAME_LAST_BIT)
            phase <= PH_EXTRA;
        // extra bits just run the counter up
        default:
          phase <= phase;
      endcase
    end
  end

  // bit counter, kept through cs_n release for the length check
  always_ff @(posedge clk)
  begin
    if (reset)
      bit_cnt <= '0;
    else if (phase == PH_IDLE && cs_fall)
      bit_cnt <= '0;
    else if (phase != PH_IDLE && sclk_rise && bit_cnt != BIT_CNT_MAX)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // mosi in at lsb, msb first on the wire
  always_ff @(posedge clk)
  begin
    if (phase != PH_IDLE && sclk_rise)
      frame <= {frame[FRAME_BITS-2:0], mosi_sync[1]};
  end

  ////////////////////
  // strobes

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bus.wr_stb <= 1'b0;
      bus.rd_stb <= 1'b0;
    end
    else
    begin
      // only a frame of exactly 16 bits writes
      bus.wr_stb <= cs_rise && (bit_cnt == FRAME_DONE_CNT);
      // address byte complete on this edge
      bus.rd_stb <= sclk_rise && (phase == PH_ADDR) && (bit_cnt == ADDR_LAST_BIT);
    end
  end

  always_ff @(posedge clk)
  begin
    if (cs_rise)
    begin
      bus.wr_addr <= frame[FRAME_BITS-1 -: BYTE_BITS];
      bus.wr_val  <= frame[BYTE_BITS-1:0];
    end
    // includes the bit arriving on this edge
    if (sclk_rise)
      bus.rd_addr <= {frame[BYTE_BITS-2:0], mosi_sync[1]};
  end

  ////////////////////
  // readback out

  // one bit per falling edge once the address is in
  assign tx_step = sclk_fall && (phase == PH_DATA || phase == PH_EXTRA);

  always_ff @(posedge clk)
  begin
    if (bus.rd_stb)
      tx_shift <= bus.rd_data;
    else if (tx_step)
      tx_shift <= tx_shift << 1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      sdo_q <= 1'b0;
    else if (phase == PH_IDLE)
      sdo_q <= 1'b0;
    else if (tx_step)
      sdo_q <= tx_shift[BYTE_BITS-1];
  end

  // quiet while deselected, no sync lag on release
  assign sdo = sdo_q & ~cs_n;

endmodule

//--- hdl/smu_ctrl_regs.sv
// smu control registers with set, clear and toggle writes
// soft reset, readback decode, chip select and miso routing

`timescale 1ns/1ps

module smu_ctrl_regs
  import smu_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  reg_bus_if.regs                bus,
  input  logic                   sdo,
  input  logic                   dev_sel_n,
  input  logic [NUM_DEVICES-1:0] dev_miso,
  input  mon_rails_t             mon_rails,
  output logic                   miso,
  output logic [NUM_DEVICES-1:0] dev_cs_n,
  output ctrl_nibble_t           led,
  output ctrl_nibble_t           dac_ctl,
  output ctrl_nibble_t           rails_ctl,
  output ctrl_nibble_t           clamp1_ctl,
  output ctrl_nibble_t           rails_oe
);

  // internal device select mux register
  ctrl_nibble_t mux_q;
  logic         soft_reset;
  logic [NUM_DEVICES-1:0] dev_en;

  ////////////////////
  // update rule

  // low nibble sets and high nibble clears
  // a bit hit by both toggles
  function automatic ctrl_nibble_t apply_update(ctrl_nibble_t cur, logic [7:0] val);
    ctrl_nibble_t set_bits;
    ctrl_nibble_t clr_bits;
    ctrl_nibble_t both;
    set_bits = val[3:0];
    clr_bits = val[7:4];
    both     = set_bits & clr_bits;
    if (both != '0)
      // overlap inverts only those bits
      return cur ^ both;
    else
      return (cur | set_bits) & ~clr_bits;
  endfunction

  assign soft_reset = bus.wr_stb && (bus.wr_addr == ADDR_SOFT_RESET);

  ////////////////////
  // registers

  always_ff @(posedge clk)
  begin
    if (reset || soft_reset)
    begin
      led        <= RST_DEFAULT;
      mux_q      <= RST_DEFAULT;
      dac_ctl    <= RST_DEFAULT;
      rails_ctl  <= RST_DEFAULT;
      clamp1_ctl <= RST_CLAMP1;
      rails_oe   <= RST_RAILS_OE;
    end
    else if (bus.wr_stb)
    begin
      case (bus.wr_addr)
        ADDR_LED:      led        <= apply_update(led, bus.wr_val);
        ADDR_MUX:      mux_q      <= apply_update(mux_q, bus.wr_val);
        ADDR_DAC:      dac_ctl    <= apply_update(dac_ctl, bus.wr_val);
        ADDR_RAILS:    rails_ctl  <= apply_update(rails_ctl, bus.wr_val);
        ADDR_CLAMP1:   clamp1_ctl <= apply_update(clamp1_ctl, bus.wr_val);
        ADDR_RAILS_OE: rails_oe   <= apply_update(rails_oe, bus.wr_val);
        // unknown address leaves every register alone
        default:       led        <= led;
      endcase
    end
  end

  ////////////////////
  // readback

  // sampled by the receiver in its read strobe cycle
  always_comb
  begin
    case (bus.rd_addr)
      ADDR_LED:       bus.rd_data = read_byte_t'(led);
      ADDR_MON_RAILS: bus.rd_data = read_byte_t'(mon_rails);
      default:        bus.rd_data = '0;
    endcase
  end

  ////////////////////
  // device routing

  // one mux bit per downstream device
  assign dev_en = mux_q[NUM_DEVICES-1:0];

  // second host select low hands the bus to the devices
  always_comb
  begin
    if (dev_sel_n)
    begin
      dev_cs_n = '1;
      miso     = sdo;
    end
    else
    begin
      dev_cs_n = ~dev_en;
      // wired-or of whichever devices are selected
      miso     = |(dev_en & dev_miso);
    end
  end

endmodule

//--- hdl/smu_spi_top.sv
// smu spi control block top level
// host spi receiver and control register block on one register bus

`timescale 1ns/1ps

module smu_spi_top
  import smu_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,

  // host spi
  input  logic                   sclk,
  input  logic                   cs_n,
  input  logic                   mosi,
  // second host select, routes to the devices
  input  logic                   dev_sel_n,
  output logic                   miso,

  // downstream spi devices
  input  logic [NUM_DEVICES-1:0] dev_miso,
  output logic [NUM_DEVICES-1:0] dev_cs_n,

  // board controls
  input  mon_rails_t             mon_rails,
  output ctrl_nibble_t           led,
  output ctrl_nibble_t           dac_ctl,
  output ctrl_nibble_t           rails_ctl,
  output ctrl_nibble_t           clamp1_ctl,
  output ctrl_nibble_t           rails_oe
);

  // register side serial out, before the miso mux
  logic sdo;

  reg_bus_if i_reg_bus ();

  ////////////////////
  // host spi in

  spi_frame_rx i_spi_frame_rx (
    .clk   (clk),
    .reset (reset),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .sdo   (sdo),
    .bus   (i_reg_bus.rx)
  );

  ////////////////////
  // registers and routing

  smu_ctrl_regs i_smu_ctrl_regs (
    .clk        (clk),
    .reset      (reset),
    .bus        (i_reg_bus.regs),
    .sdo        (sdo),
    .dev_sel_n  (dev_sel_n),
    .dev_miso   (dev_miso),
    .mon_rails  (mon_rails),
    .miso       (miso),
    .dev_cs_n   (dev_cs_n),
    .led        (led),
    .dac_ctl    (dac_ctl),
    .rails_ctl  (rails_ctl),
    .clamp1_ctl (clamp1_ctl),
    .rails_oe   (rails_oe)
  );

endmodule

//--- verif/tb_clock_gen.sv
// testbench clock and reset source
// 10 ns clock, reset held for the first 5 cycles

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // released on a rising edge, matching the synchronous reset
  initial
  begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- verif/tb_smu_spi_top.sv
// testbench for the smu spi control block
// lfsr stimulus, spi master, register model, checks and report

`timescale 1ns/1ps

module tb_smu_spi_top
  import spi_frame_pkg::*;
  import smu_regs_pkg::*;
();

  localparam int N_WRITES = 200;
  localparam int N_READS  = 24;
  localparam int N_BADLEN = 18;
  localparam int N_ROUTE  = 12;
  // each frame takes well under 300 cycles
  localparam int TIMEOUT_CYCLES = (N_WRITES + N_READS + N_BADLEN + N_ROUTE) * 300 + 100;

  logic                   clk;
  logic                   reset;
  logic                   sclk;
  logic                   cs_n;
  logic                   mosi;
  logic                   dev_sel_n;
  logic [NUM_DEVICES-1:0] dev_miso;
  mon_rails_t             mon_rails;
  logic                   miso;
  logic [NUM_DEVICES-1:0] dev_cs_n;
  ctrl_nibble_t           led, dac_ctl, rails_ctl, clamp1_ctl, rails_oe;

  // reference register values
  ctrl_nibble_t m_led, m_mux, m_dac, m_rails, m_clamp1, m_rails_oe;

  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  logic [15:0] lfsr_state = 16'd61392;

  tb_clock_gen i_tb_clock_gen (.clk(clk), .reset(reset));

  smu_spi_top i_smu_spi_top (
    .clk (clk), .reset (reset), .sclk (sclk), .cs_n (cs_n), .mosi (mosi),
    .dev_sel_n (dev_sel_n), .miso (miso), .dev_miso (dev_miso), .dev_cs_n (dev_cs_n),
    .mon_rails (mon_rails), .led (led), .dac_ctl (dac_ctl), .rails_ctl (rails_ctl),
    .clamp1_ctl (clamp1_ctl), .rails_oe (rails_oe)
  );

  ////////////////////
  // random source

  // taps for x^16 + x^14 + x^13 + x^11 + 1
  // stepped once per bit taken
  function logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function reg_addr_t writable_addr(int idx);
    case (idx % 6)
      0:       return 8'd7;
      1:       return 8'd8;
      2:       return 8'd9;
      3:       return 8'd10;
      4:       return 8'd15;
      default: return 8'd24;
    endcase
  endfunction

  ////////////////////
  // reference model

  task automatic model_reset();
    m_led      = 4'b0000;
    m_mux      = 4'b0000;
    m_dac      = 4'b0000;
    m_rails    = 4'b0000;
    m_clamp1   = 4'b1111;
    m_rails_oe = 4'b0001;
  endtask

  // overlap toggles only the overlapping bits
  // otherwise clear wins over set
  function automatic ctrl_nibble_t nibble_after_write(ctrl_nibble_t old, logic [7:0] val);
    ctrl_nibble_t result;
    logic         overlap;
    overlap = 1'b0;
    for (int b = 0; b < 4; b++)
      if (val[b] && val[b+4])
        overlap = 1'b1;
    for (int b = 0; b < 4; b++)
    begin
      if (overlap)
        result[b] = (val[b] && val[b+4]) ? ~old[b] : old[b];
      else if (val[b+4])
        result[b] = 1'b0;
      else if (val[b])
        result[b] = 1'b1;
      else
        result[b] = old[b];
    end
    return result;
  endfunction

  task automatic model_write(reg_addr_t addr, logic [7:0] val);
    case (addr)
      8'd7:    m_led      = nibble_after_write(m_led, val);
      8'd8:    m_mux      = nibble_after_write(m_mux, val);
      8'd9:    m_dac      = nibble_after_write(m_dac, val);
      8'd10:   m_rails    = nibble_after_write(m_rails, val);
      8'd11:   model_reset();
      8'd15:   m_clamp1   = nibble_after_write(m_clamp1, val);
      8'd24:   m_rails_oe = nibble_after_write(m_rails_oe, val);
      default: ;
    endcase
  endtask

  function automatic logic [7:0] readback_model(reg_addr_t addr, mon_rails_t mon);
    if (addr == 8'd7)
      return {4'b0000, m_led};
    else if (addr == 8'd19)
      return {6'b000000, mon};
    return 8'h00;
  endfunction

  function automatic logic [NUM_DEVICES-1:0] expected_cs(ctrl_nibble_t mux);
    logic [NUM_DEVICES-1:0] cs;
    for (int d = 0; d < NUM_DEVICES; d++)
      cs[d] = !mux[d];
    return cs;
  endfunction

  function automatic logic expected_miso(ctrl_nibble_t mux, logic [NUM_DEVICES-1:0] dm);
    logic any;
    any = 1'b0;
    for (int d = 0; d < NUM_DEVICES; d++)
      if (mux[d] && dm[d])
        any = 1'b1;
    return any;
  endfunction

  ////////////////////
  // checks

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_regs(string name);
    check_value({name, " led"}, m_led, led);
    check_value({name, " dac_ctl"}, m_dac, dac_ctl);
    check_value({name, " rails_ctl"}, m_rails, rails_ctl);
    check_value({name, " clamp1_ctl"}, m_clamp1, clamp1_ctl);
    check_value({name, " rails_oe"}, m_rails_oe, rails_oe);
  endtask

  ////////////////////
  // spi master

  // mode 0 with a half period of 4 clk cycles
  // bits right aligned and sent msb first
  task automatic spi_frame(logic [31:0] bits, int nbits, output logic [31:0] rx);
    rx = '0;
    @(posedge clk);
    cs_n <= 1'b0;
    sclk <= 1'b0;
    repeat (4) @(posedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      // new bit goes out with the falling edge
      mosi <= bits[nbits-1-i];
      repeat (3) @(posedge clk);
      @(negedge clk);
      rx = {rx[30:0], miso};
      @(posedge clk);
      sclk <= 1'b1;
      repeat (4) @(posedge clk);
      sclk <= 1'b0;
    end
    repeat (4) @(posedge clk);
    cs_n <= 1'b1;
    // strobe plus register update settle well inside this
    repeat (8) @(posedge clk);
  endtask

  task automatic write_frame(reg_addr_t addr, logic [7:0] val);
    logic [31:0] rx;
    spi_frame({16'h0000, addr, val}, 16, rx);
    model_write(addr, val);
  endtask

  ////////////////////
  // stimulus

  initial
  begin
    reg_addr_t   addr;
    logic [7:0]  val;
    logic [7:0]  expected;
    logic [31:0] rx;
    logic [31:0] bits;
    int          len;
    sclk      = 1'b0;
    cs_n      = 1'b1;
    mosi      = 1'b0;
    dev_sel_n = 1'b1;
    dev_miso  = '0;
    mon_rails = '0;
    model_reset();
    @(negedge reset);
    @(negedge clk);
    check_regs("after reset");
    check_value("after reset dev_cs_n", 4'hf, dev_cs_n);

    // random writes with a soft reset now and then
    for (int n = 0; n < N_WRITES; n++)
    begin
      if (rand_bits(4) == 0)
        addr = ADDR_SOFT_RESET;
      else if (rand_bits(3) < 6)
        addr = writable_addr(rand_bits(3));
      else
        addr = rand_bits(8);
      val = rand_bits(8);
      write_frame(addr, val);
      @(negedge clk);
      if (addr == ADDR_SOFT_RESET)
        check_regs("soft reset");
      else
        check_regs("random write");
    end

    // readback on bits 9 to 16
    for (int n = 0; n < N_READS; n++)
    begin
      @(posedge clk);
      mon_rails <= rand_bits(2);
      len = rand_bits(2);
      addr = (len == 0) ? 8'd7 : (len == 1) ? 8'd19 : rand_bits(8);
      val = rand_bits(8);
      @(posedge clk);
      expected = readback_model(addr, mon_rails);
      spi_frame({16'h0000, addr, val}, 16, rx);
      model_write(addr, val);
      check_value("readback", expected, rx[7:0]);
    end

    // short and long frames must not write
    for (int n = 0; n < N_BADLEN; n++)
    begin
      len = rand_bits(2);
      len = (len == 0) ? 8 : (len == 1) ? 12 : 24;
      addr = writable_addr(rand_bits(3));
      val = rand_bits(8);
      // a 24 bit frame also ends in a full address and value pair
      bits = {8'h00, addr, addr, val} >> (24 - len);
      spi_frame(bits, len, rx);
      @(negedge clk);
      check_regs("bad length");
    end

    // device routing
    for (int n = 0; n < N_ROUTE; n++)
    begin
      write_frame(ADDR_MUX, rand_bits(8));
      for (int k = 0; k < 4; k++)
      begin
        @(posedge clk);
        dev_sel_n <= 1'b0;
        dev_miso  <= rand_bits(NUM_DEVICES);
        @(negedge clk);
        check_value("route dev_cs_n", expected_cs(m_mux), dev_cs_n);
        check_value("route miso", expected_miso(m_mux, dev_miso), miso);
      end
      @(posedge clk);
      dev_sel_n <= 1'b1;
      @(negedge clk);
      check_value("deselect dev_cs_n", 4'hf, dev_cs_n);
      check_value("deselect miso", 1'b0, miso);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // run limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

//--- filelist.f
hdl/spi_frame_pkg.sv
hdl/smu_regs_pkg.sv
hdl/reg_bus_if.sv
hdl/spi_frame_rx.sv
hdl/smu_ctrl_regs.sv
hdl/smu_spi_top.sv
verif/tb_clock_gen.sv
verif/tb_smu_spi_top.sv

//--- Bender.yml
package:
  name: smu_spi_ctrl

sources:
  # packages first, then interface and modules
  - files:
      - hdl/spi_frame_pkg.sv
      - hdl/smu_regs_pkg.sv
      - hdl/reg_bus_if.sv
      - hdl/spi_frame_rx.sv
      - hdl/smu_ctrl_regs.sv
      - hdl/smu_spi_top.sv

  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_smu_spi_top.sv
